//--- hdl/metric_pkg.sv
package metric_pkg;

	////////////////////////////////////////////////////////////
	// metric widths
	////////////////////////////////////////////////////////////

	// branch metrics, alpha, sys, apriori, llr and extrinsic
	// all wrap at 16 bits
	typedef logic signed [15:0] metric_t;

	// backward metrics need headroom over a whole block
	typedef logic signed [18:0] beta_t;

	// 8-state constituent code
	localparam int N_STATES = 8;

	// beta start vector
	// state 0 starts at 0, the rest well below it
	localparam beta_t BETA_INIT_OTHER = beta_t'(-128);

	////////////////////////////////////////////////////////////
	// trellis connections
	////////////////////////////////////////////////////////////

	// successor of state s on the branch that takes -gamma in l1
	// index 0 is the leftmost entry
	localparam logic [0:N_STATES-1][2:0] SUCC_PLUS = {
		3'd4, 3'd0, 3'd1, 3'd5, 3'd6, 3'd2, 3'd3, 3'd7
	};

	// successor of state s on the other branch
	localparam logic [0:N_STATES-1][2:0] SUCC_MINUS = {
		3'd0, 3'd4, 3'd5, 3'd1, 3'd2, 3'd6, 3'd7, 3'd3
	};

	// per-state branch metric choice
	// 1 selects gamma2 (states 2 to 5), 0 selects gamma1
	localparam logic [N_STATES-1:0] GAMMA_SEL = 8'b0011_1100;

endpackage

//--- hdl/block_pkg.sv
package block_pkg;

	////////////////////////////////////////////////////////////
	// block sizing
	////////////////////////////////////////////////////////////

	localparam int MAX_BLK = 64;
	localparam int MIN_BLK = 8;
	localparam int ADDR_W  = 6;

	// store read to extrinsic write, in cycles
	localparam int LLR_PIPE_DEPTH = 4;

	// block length, wide enough to hold MAX_BLK itself
	typedef logic [6:0] blk_len_t;

	// step index inside one block
	typedef logic [ADDR_W-1:0] addr_t;

	////////////////////////////////////////////////////////////
	// records
	////////////////////////////////////////////////////////////

	// one trellis step as delivered by the forward half
	typedef struct packed {
		metric_pkg::metric_t                                gamma1;
		metric_pkg::metric_t                                gamma2;
		metric_pkg::metric_t [0:metric_pkg::N_STATES-1]     alpha;
		metric_pkg::metric_t                                sys;
		metric_pkg::metric_t                                apriori;
	} step_rec_t;

	// raw extrinsic difference on its way to the output buffer
	typedef struct packed {
		logic                valid;
		addr_t               index;
		metric_pkg::metric_t diff;
	} llr_item_t;

	// block controller
	typedef enum logic [2:0] {
		IDLE,
		LOAD,
		BACKWARD,
		DRAIN,
		OUTPUT
	} ctrl_state_t;

endpackage

//--- hdl/decode_ctrl.sv
`timescale 1ns/1ps

module decode_ctrl (
	input  logic                clk,
	input  logic                rst,
	input  logic                start_i,
	input  block_pkg::blk_len_t blk_len_i,
	input  logic                in_valid_i,
	output logic                ready_o,
	output logic                wr_en_o,
	output block_pkg::addr_t    wr_addr_o,
	output block_pkg::addr_t    rd_addr_o,
	output logic                rec_valid_o,
	output logic                beta_init_o,
	output block_pkg::addr_t    out_rd_addr_o,
	output logic                out_valid_o,
	output logic                out_last_o
);
	import block_pkg::*;

	ctrl_state_t state;
	// length captured at start
	blk_len_t    blk_len;
	blk_len_t    last_idx;
	// shared step counter
	// up in LOAD, down in BACKWARD, up in DRAIN and OUTPUT
	blk_len_t    cnt;
	logic        len_ok;
	logic        accept;

	assign last_idx = blk_len - blk_len_t'(1);
	assign len_ok   = (blk_len_i >= blk_len_t'(MIN_BLK)) && (blk_len_i <= blk_len_t'(MAX_BLK));

	// records only taken while loading
	assign ready_o = (state == LOAD);
	assign accept  = ready_o && in_valid_i;
	assign wr_en_o = accept;

	// all three address streams come from the one counter
	assign wr_addr_o     = cnt[ADDR_W-1:0];
	assign rd_addr_o     = cnt[ADDR_W-1:0];
	assign out_rd_addr_o = cnt[ADDR_W-1:0];

	// beta start vector loads with the last record
	// first backward read follows in the next cycle
	assign beta_init_o = accept && (cnt == last_idx);

	always_ff @(posedge clk) begin
		if (state == IDLE && start_i && len_ok)
			blk_len <= blk_len_i;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			cnt   <= '0;
		end else begin
			case (state)
				IDLE: begin
					cnt <= '0;
					// bad lengths are dropped silently
					if (start_i && len_ok)
						state <= LOAD;
				end
				LOAD: begin
					if (accept) begin
						if (cnt == last_idx) begin
							state <= BACKWARD;
						end else begin
							cnt <= cnt + blk_len_t'(1);
						end
					end
				end
				BACKWARD: begin
					// reads N-1 down to 0, one per cycle
					if (cnt == '0) begin
						state <= DRAIN;
					end else begin
						cnt <= cnt - blk_len_t'(1);
					end
				end
				DRAIN: begin
					// store read plus LLR_PIPE_DEPTH, so index 0 is written
					if (cnt == blk_len_t'(LLR_PIPE_DEPTH)) begin
						state <= OUTPUT;
						cnt   <= '0;
					end else begin
						cnt <= cnt + blk_len_t'(1);
					end
				end
				OUTPUT: begin
					if (cnt == last_idx) begin
						state <= IDLE;
					end else begin
						cnt <= cnt + blk_len_t'(1);
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// flags line up with store data and buffer read data
	always_ff @(posedge clk) begin
		if (rst) begin
			rec_valid_o <= 1'b0;
			out_valid_o <= 1'b0;
			out_last_o  <= 1'b0;
		end else begin
			rec_valid_o <= (state == BACKWARD);
			out_valid_o <= (state == OUTPUT);
			out_last_o  <= (state == OUTPUT) && (cnt == last_idx);
		end
	end

endmodule

//--- hdl/step_store.sv
`timescale 1ns/1ps

module step_store (
	input  logic                 clk,
	input  logic                 wr_en_i,
	input  block_pkg::addr_t     wr_addr_i,
	input  block_pkg::step_rec_t wr_rec_i,
	input  block_pkg::addr_t     rd_addr_i,
	output block_pkg::step_rec_t rd_rec_o
);
	import block_pkg::*;

	////////////////////////////////////////////////////////////
	// one block of step records
	////////////////////////////////////////////////////////////

	// 12 words per entry
	// gamma pair, eight alphas, sys and apriori
	step_rec_t mem [MAX_BLK];

	// forward order fill during load
	always_ff @(posedge clk) begin
		if (wr_en_i)
			mem[wr_addr_i] <= wr_rec_i;
	end

	// registered read, data one cycle after the address
	// read side walks the block backwards
	always_ff @(posedge clk) begin
		rd_rec_o <= mem[rd_addr_i];
	end

endmodule

//--- hdl/beta_recursion.sv
`timescale 1ns/1ps

module beta_recursion (
	input  logic                                          clk,
	input  logic                                          rst,
	input  logic                                          beta_init_i,
	input  logic                                          rec_valid_i,
	input  block_pkg::step_rec_t                          rec_i,
	input  block_pkg::addr_t                              idx_i,
	output block_pkg::step_rec_t                          rec_o,
	output metric_pkg::metric_t [0:metric_pkg::N_STATES-1] nbeta_o,
	output block_pkg::addr_t                              idx_o,
	output logic                                          valid_o
);
	import metric_pkg::*;
	import block_pkg::*;

	// beta of the step after the one being read
	beta_t beta     [N_STATES];
	beta_t beta_nxt [N_STATES];
	// read address delayed to match store latency
	addr_t idx_q;

	////////////////////////////////////////////////////////////
	// add-compare-select
	////////////////////////////////////////////////////////////

	always_comb begin
		beta_t g;
		beta_t up;
		beta_t dn;
		for (int s = 0; s < N_STATES; s++) begin
			// sign extend the chosen branch metric
			g  = beta_t'(GAMMA_SEL[s] ? rec_i.gamma2 : rec_i.gamma1);
			up = beta[SUCC_PLUS[s]] + g;
			dn = beta[SUCC_MINUS[s]] - g;
			beta_nxt[s] = (up > dn) ? up : dn;
		end
	end

	always_ff @(posedge clk) begin
		idx_q <= idx_i;
		// start vector once per block, then one step per record
		if (beta_init_i) begin
			beta[0] <= '0;
			for (int s = 1; s < N_STATES; s++)
				beta[s] <= BETA_INIT_OTHER;
		end else if (rec_valid_i) begin
			beta <= beta_nxt;
		end
		// record goes on with beta before this step's update
		if (rec_valid_i) begin
			rec_o <= rec_i;
			idx_o <= idx_q;
			// normalized to state 0, cut to metric width
			for (int s = 0; s < N_STATES; s++)
				nbeta_o[s] <= metric_t'(beta[s] - beta[0]);
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			valid_o <= 1'b0;
		else
			valid_o <= rec_valid_i;
	end

endmodule

//--- hdl/llr_max_tree.sv
`timescale 1ns/1ps

module llr_max_tree (
	input  logic                                          clk,
	input  logic                                          rst,
	input  logic                                          valid_i,
	input  block_pkg::step_rec_t                          rec_i,
	input  metric_pkg::metric_t [0:metric_pkg::N_STATES-1] nbeta_i,
	input  block_pkg::addr_t                              idx_i,
	output block_pkg::llr_item_t                          item_o
);
	import metric_pkg::*;
	import block_pkg::*;

	localparam int N_PAIR = N_STATES / 2;

	// per-state branch metric
	metric_t g [N_STATES];
	// stage 1, branch sums
	metric_t l1_q [N_STATES];
	metric_t l2_q [N_STATES];
	// stage 2, pairwise maxima
	metric_t m1_q [N_PAIR];
	metric_t m2_q [N_PAIR];
	// stage 3 combinational tops
	metric_t l1_top;
	metric_t l2_top;
	metric_t diff_q;
	// side data carried alongside
	metric_t    sys_q  [2];
	metric_t    apri_q [2];
	addr_t      idx_q  [3];
	logic [2:0] vld_q;

	function automatic metric_t max2(input metric_t a, input metric_t b);
		return (a > b) ? a : b;
	endfunction

	always_comb begin
		for (int s = 0; s < N_STATES; s++)
			g[s] = GAMMA_SEL[s] ? rec_i.gamma2 : rec_i.gamma1;
	end

	////////////////////////////////////////////////////////////
	// pipeline
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		// stage 1
		// l1 takes -g into the plus successor, l2 +g into the minus one
		for (int s = 0; s < N_STATES; s++) begin
			l1_q[s] <= rec_i.alpha[s] - g[s] + nbeta_i[SUCC_PLUS[s]];
			l2_q[s] <= rec_i.alpha[s] + g[s] + nbeta_i[SUCC_MINUS[s]];
		end
		sys_q[0]  <= rec_i.sys;
		apri_q[0] <= rec_i.apriori;
		idx_q[0]  <= idx_i;
		// stage 2
		for (int j = 0; j < N_PAIR; j++) begin
			m1_q[j] <= max2(l1_q[2*j], l1_q[2*j+1]);
			m2_q[j] <= max2(l2_q[2*j], l2_q[2*j+1]);
		end
		sys_q[1]  <= sys_q[0];
		apri_q[1] <= apri_q[0];
		idx_q[1]  <= idx_q[0];
		// stage 3
		// strip channel and prior parts from the llr
		diff_q   <= l1_top - l2_top - sys_q[1] - apri_q[1];
		idx_q[2] <= idx_q[1];
	end

	// last two levels of the tree feed the stage 3 register
	assign l1_top = max2(max2(m1_q[0], m1_q[1]), max2(m1_q[2], m1_q[3]));
	assign l2_top = max2(max2(m2_q[0], m2_q[1]), max2(m2_q[2], m2_q[3]));

	always_ff @(posedge clk) begin
		if (rst)
			vld_q <= '0;
		else
			vld_q <= {vld_q[1:0], valid_i};
	end

	assign item_o = '{valid: vld_q[2], index: idx_q[2], diff: diff_q};

endmodule

//--- hdl/extrinsic_buffer.sv
`timescale 1ns/1ps

module extrinsic_buffer (
	input  logic                 clk,
	input  block_pkg::llr_item_t item_i,
	input  block_pkg::addr_t     rd_addr_i,
	output metric_pkg::metric_t  extrinsic_o
);
	import metric_pkg::*;
	import block_pkg::*;

	// scaled values, indexed by trellis step
	metric_t     ext_mem [MAX_BLK];
	metric_t     diff;
	// magnitude and the quarter taken off it
	logic [15:0] mag;
	logic [15:0] quarter;
	logic        round_up;
	metric_t     scaled;

	////////////////////////////////////////////////////////////
	// scale by about 3/4
	////////////////////////////////////////////////////////////

	assign diff = item_i.diff;
	assign mag  = diff[15] ? -diff : diff;

	// mag/4, rounded up only when the remainder is 3
	assign round_up = (mag[1:0] == 2'b11);
	assign quarter  = (mag >> 2) + {15'd0, round_up};

	// shrink towards zero on both signs
	assign scaled = diff[15] ? diff + metric_t'(quarter) : diff - metric_t'(quarter);

	////////////////////////////////////////////////////////////
	// reorder buffer
	////////////////////////////////////////////////////////////

	// written in backward order as items arrive
	always_ff @(posedge clk) begin
		if (item_i.valid)
			ext_mem[item_i.index] <= scaled;
	end

	// read back 0 to N-1, one cycle latency
	always_ff @(posedge clk) begin
		extrinsic_o <= ext_mem[rd_addr_i];
	end

endmodule

//--- hdl/beta_llr_top.sv
`timescale 1ns/1ps

module beta_llr_top (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 start_i,
	input  block_pkg::blk_len_t  blk_len_i,
	input  logic                 in_valid_i,
	input  block_pkg::step_rec_t in_rec_i,
	output logic                 ready_o,
	output logic                 out_valid_o,
	output logic                 out_last_o,
	output metric_pkg::metric_t  extrinsic_o
);
	import metric_pkg::*;
	import block_pkg::*;

	// controller to store
	logic      wr_en;
	addr_t     wr_addr;
	addr_t     rd_addr;
	// controller to datapath
	logic      rec_valid;
	logic      beta_init;
	addr_t     out_rd_addr;
	// store to beta recursion
	step_rec_t rd_rec;
	// beta recursion to max tree
	step_rec_t              br_rec;
	metric_t [0:N_STATES-1] br_nbeta;
	addr_t                  br_idx;
	logic                   br_valid;
	// max tree to output buffer
	llr_item_t              llr_item;

	decode_ctrl u_ctrl (
		.clk           (clk),
		.rst           (rst),
		.start_i       (start_i),
		.blk_len_i     (blk_len_i),
		.in_valid_i    (in_valid_i),
		.ready_o       (ready_o),
		.wr_en_o       (wr_en),
		.wr_addr_o     (wr_addr),
		.rd_addr_o     (rd_addr),
		.rec_valid_o   (rec_valid),
		.beta_init_o   (beta_init),
		.out_rd_addr_o (out_rd_addr),
		.out_valid_o   (out_valid_o),
		.out_last_o    (out_last_o)
	);

	step_store u_store (
		.clk       (clk),
		.wr_en_i   (wr_en),
		.wr_addr_i (wr_addr),
		.wr_rec_i  (in_rec_i),
		.rd_addr_i (rd_addr),
		.rd_rec_o  (rd_rec)
	);

	// index follows the read address, realigned inside the recursion
	beta_recursion u_beta (
		.clk         (clk),
		.rst         (rst),
		.beta_init_i (beta_init),
		.rec_valid_i (rec_valid),
		.rec_i       (rd_rec),
		.idx_i       (rd_addr),
		.rec_o       (br_rec),
		.nbeta_o     (br_nbeta),
		.idx_o       (br_idx),
		.valid_o     (br_valid)
	);

	llr_max_tree u_tree (
		.clk     (clk),
		.rst     (rst),
		.valid_i (br_valid),
		.rec_i   (br_rec),
		.nbeta_i (br_nbeta),
		.idx_i   (br_idx),
		.item_o  (llr_item)
	);

	extrinsic_buffer u_ext (
		.clk         (clk),
		.item_i      (llr_item),
		.rd_addr_i   (out_rd_addr),
		.extrinsic_o (extrinsic_o)
	);

endmodule

//--- verif/beta_llr_asserts.sv
`timescale 1ns/1ps

module beta_llr_asserts (
	input logic                clk,
	input logic                rst,
	input logic                start_i,
	input block_pkg::blk_len_t blk_len_i,
	input logic                in_valid_i,
	input logic                ready_o,
	input logic                out_valid_o,
	input logic                out_last_o
);
	import block_pkg::*;

	// block tracker, from accepted start to out_last_o
	logic     busy;
	logic     loading;
	logic     start_ok;
	blk_len_t len_q;
	blk_len_t load_cnt;
	blk_len_t out_cnt;

	// controller is idle again in the cycle that carries out_last_o
	assign start_ok = start_i && (!busy || out_last_o) &&
		(blk_len_i >= blk_len_t'(MIN_BLK)) && (blk_len_i <= blk_len_t'(MAX_BLK));

	always_ff @(posedge clk) begin
		if (rst) begin
			busy     <= 1'b0;
			loading  <= 1'b0;
			len_q    <= '0;
			load_cnt <= '0;
			out_cnt  <= '0;
		end else if (start_ok) begin
			busy     <= 1'b1;
			loading  <= 1'b1;
			len_q    <= blk_len_i;
			load_cnt <= '0;
			out_cnt  <= '0;
		end else begin
			if (out_last_o)
				busy <= 1'b0;
			if (ready_o && in_valid_i) begin
				load_cnt <= load_cnt + blk_len_t'(1);
				if (load_cnt + blk_len_t'(1) == len_q)
					loading <= 1'b0;
			end
			if (out_valid_o)
				out_cnt <= out_cnt + blk_len_t'(1);
		end
	end

	////////////////////////////////////////////////////////////
	// protocol checks
	////////////////////////////////////////////////////////////

	a_ready_in_load: assert property (@(posedge clk) disable iff (rst) ready_o |-> loading)
		else $error("ready_o high outside a load phase");

	a_last_has_valid: assert property (@(posedge clk) disable iff (rst) out_last_o |-> out_valid_o)
		else $error("out_last_o without out_valid_o");

	// no output outside a block, and never more than N of them
	a_valid_in_block: assert property (@(posedge clk) disable iff (rst)
		out_valid_o |-> (busy && !loading && out_cnt < len_q))
		else $error("out_valid_o outside the output phase of a block");

	a_last_count: assert property (@(posedge clk) disable iff (rst)
		out_last_o |-> (out_cnt + blk_len_t'(1) == len_q))
		else $error("block ended after the wrong number of outputs");

endmodule

//--- verif/tb_top.sv
`timescale 1ns/1ps

module tb_top;
	import metric_pkg::*;
	import block_pkg::*;

	localparam int RESET_CYC = 10;
	localparam int IDLE_CYC  = 20;
	// all block lengths in run order
	// the gap test loads its block twice
	localparam int SUM_N     = 16 + 8 + 16 + 16 + 8 + 64 + 23 + 12;
	// eight blocks plus the idle check
	localparam int N_RUNS    = 9;
	localparam int LIMIT_CYC = 2 * (3 * SUM_N + 20 * N_RUNS) + RESET_CYC;

	logic                clk;
	logic                rst;
	logic                start_i;
	blk_len_t            blk_len_i;
	logic                in_valid_i;
	step_rec_t           in_rec_i;
	logic                ready_o;
	logic                out_valid_o;
	logic                out_last_o;
	metric_t             extrinsic_o;

	// block under test and the expected extrinsics
	step_rec_t blk  [MAX_BLK];
	metric_t   exp_q [$];
	// directed diffs with u mod 4 from 0 to 3 on both signs
	int        dir_diff [8] = '{12, 13, 14, 15, -12, -13, -14, -15};
	int        b2b_len  [3] = '{MIN_BLK, MAX_BLK, 23};
	int        cyc = 0;
	int        err_test = 0;
	int        err_total = 0;
	int        tests_run = 0;
	int        tests_failed = 0;

	beta_llr_top UUT (
		.clk         (clk),
		.rst         (rst),
		.start_i     (start_i),
		.blk_len_i   (blk_len_i),
		.in_valid_i  (in_valid_i),
		.in_rec_i    (in_rec_i),
		.ready_o     (ready_o),
		.out_valid_o (out_valid_o),
		.out_last_o  (out_last_o),
		.extrinsic_o (extrinsic_o)
	);

	bind beta_llr_top beta_llr_asserts u_asserts (
		.clk         (clk),
		.rst         (rst),
		.start_i     (start_i),
		.blk_len_i   (blk_len_i),
		.in_valid_i  (in_valid_i),
		.ready_o     (ready_o),
		.out_valid_o (out_valid_o),
		.out_last_o  (out_last_o)
	);

	always #5 clk = ~clk;

	// cycle count for the timeout and the latency check
	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= LIMIT_CYC) begin
			$display("timeout: run stopped after %0d cycles", cyc);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// reporting
	////////////////////////////////////////////////////////////

	task automatic report_mismatch(input int idx, input metric_t act, input metric_t want);
		$display("[ERROR] %0t: extrinsic %0d is %0d, expected %0d", $time, idx, act, want);
		err_test++;
	endtask

	task automatic report_problem(input string msg);
		$display("problem at %0t: %s", $time, msg);
		err_test++;
	endtask

	task automatic end_test(input string name);
		if (err_test == 0)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, err_test);
		tests_run++;
		if (err_test != 0)
			tests_failed++;
		err_total += err_test;
		err_test = 0;
	endtask

	////////////////////////////////////////////////////////////
	// stimulus and reference model
	////////////////////////////////////////////////////////////

	// within +-64 so that no 16-bit sum wraps
	function automatic metric_t rand_metric();
		return metric_t'(int'($urandom_range(128)) - 64);
	endfunction

	function automatic step_rec_t rand_rec();
		step_rec_t r;
		r.gamma1  = rand_metric();
		r.gamma2  = rand_metric();
		r.sys     = rand_metric();
		r.apriori = rand_metric();
		for (int s = 0; s < N_STATES; s++)
			r.alpha[s] = rand_metric();
		return r;
	endfunction

	task automatic fill_random(input int n);
		for (int i = 0; i < n; i++)
			blk[i] = rand_rec();
	endtask

	// about 3/4 with the quarter rounded up only for remainder 3
	function automatic metric_t scale_ref(input metric_t d);
		int u;
		int q;
		u = (d < 0) ? -int'(d) : int'(d);
		q = u / 4 + ((u % 4 == 3) ? 1 : 0);
		if (d > 0)
			return metric_t'(int'(d) - q);
		return metric_t'(int'(d) + q);
	endfunction

	// backward walk over blk
	// expected values queued in forward order
	task automatic predict(input int n);
		int      beta     [N_STATES];
		int      beta_nxt [N_STATES];
		int      g        [N_STATES];
		metric_t nb       [N_STATES];
		metric_t ext      [MAX_BLK];
		metric_t l1;
		metric_t l2;
		metric_t top1;
		metric_t top2;
		int      up;
		int      dn;
		beta[0] = 0;
		for (int s = 1; s < N_STATES; s++)
			beta[s] = -128;
		for (int k = n - 1; k >= 0; k--) begin
			for (int s = 0; s < N_STATES; s++) begin
				nb[s] = metric_t'(beta[s] - beta[0]);
				g[s]  = GAMMA_SEL[s] ? int'(blk[k].gamma2) : int'(blk[k].gamma1);
			end
			for (int s = 0; s < N_STATES; s++) begin
				l1 = blk[k].alpha[s] - metric_t'(g[s]) + nb[SUCC_PLUS[s]];
				l2 = blk[k].alpha[s] + metric_t'(g[s]) + nb[SUCC_MINUS[s]];
				if (s == 0 || l1 > top1)
					top1 = l1;
				if (s == 0 || l2 > top2)
					top2 = l2;
				up = beta[SUCC_PLUS[s]] + g[s];
				dn = beta[SUCC_MINUS[s]] - g[s];
				beta_nxt[s] = (up > dn) ? up : dn;
			end
			beta   = beta_nxt;
			ext[k] = scale_ref(top1 - top2 - blk[k].sys - blk[k].apriori);
		end
		for (int k = 0; k < n; k++)
			exp_q.push_back(ext[k]);
	endtask

	// one block from start to the last output
	// entered on a falling edge
	task automatic run_block(input int n, input bit gaps, input bit hold_valid);
		int      loaded;
		int      recv;
		int      last_hs;
		bit      started;
		metric_t want;
		loaded    = 0;
		recv      = 0;
		last_hs   = 0;
		started   = 0;
		start_i   = 1'b1;
		blk_len_i = blk_len_t'(n);
		@(negedge clk);
		start_i = 1'b0;
		while (recv < n) begin
			// outputs first since they only move on the rising edge
			if (out_valid_o) begin
				if (!started) begin
					assert (cyc - last_hs == n + LLR_PIPE_DEPTH + 3)
					else report_problem("first output at the wrong cycle");
				end
				started = 1;
				want    = exp_q.pop_front();
				assert (extrinsic_o == want) else report_mismatch(recv, extrinsic_o, want);
				assert (out_last_o == (recv == n - 1))
				else report_problem("out_last_o on the wrong index");
				recv++;
			end else begin
				assert (!started) else report_problem("output stream has a gap");
			end
			// ready_o follows the state only so this edge decides the handshake
			if (loaded < n && ready_o && !(gaps && $urandom_range(1) == 0)) begin
				in_valid_i = 1'b1;
				in_rec_i   = blk[loaded];
				loaded++;
				if (loaded == n)
					last_hs = cyc;
			end else begin
				// junk record that is never taken
				in_valid_i = hold_valid && (loaded == n);
				in_rec_i   = rand_rec();
				if (loaded == n)
					assert (!ready_o) else report_problem("ready_o high after a full block");
			end
			@(negedge clk);
		end
		in_valid_i = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(32'hdf35));
		clk        = 1'b0;
		rst        = 1'b1;
		start_i    = 1'b0;
		blk_len_i  = '0;
		in_valid_i = 1'b0;
		in_rec_i   = '0;
		repeat (RESET_CYC) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// quiet until the first start
		repeat (IDLE_CYC) begin
			@(negedge clk);
			assert (!ready_o && !out_valid_o && !out_last_o)
			else report_problem("outputs active before any start");
		end
		end_test("idle after reset");

		fill_random(16);
		predict(16);
		run_block(16, 0, 0);
		end_test("random block of 16");

		// zero metrics give llr 0 so diff is just -sys
		for (int i = 0; i < 8; i++) begin
			blk[i]     = '0;
			blk[i].sys = metric_t'(-dir_diff[i]);
		end
		predict(8);
		run_block(8, 0, 0);
		end_test("rounding of the 3/4 scaling");

		// same block loaded twice
		// first without gaps and then with random gaps
		fill_random(16);
		predict(16);
		run_block(16, 0, 0);
		predict(16);
		run_block(16, 1, 0);
		end_test("load with in_valid gaps");

		// beta must restart for every block
		for (int b = 0; b < 3; b++) begin
			fill_random(b2b_len[b]);
			predict(b2b_len[b]);
			run_block(b2b_len[b], 0, 0);
		end
		end_test("back-to-back blocks");

		fill_random(12);
		predict(12);
		run_block(12, 0, 1);
		end_test("in_valid held past the block");

		$display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
			err_total);
		if (err_total == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- verilog.f
hdl/metric_pkg.sv
hdl/block_pkg.sv
hdl/decode_ctrl.sv
hdl/step_store.sv
hdl/beta_recursion.sv
hdl/llr_max_tree.sv
hdl/extrinsic_buffer.sv
hdl/beta_llr_top.sv
verif/beta_llr_asserts.sv
verif/tb_top.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_top -f verilog.f -o sim_tb

# the simulator stops early on a failed bound assertion
./obj_dir/sim_tb | tee sim.log

grep -q "Simulation finished: PASS" sim.log
